// ==== logic/platform_pkg.sv ====
`default_nettype none

package platform_pkg;

    // tile codes as stored in the map nibbles
    typedef enum logic [3:0] {
        tile_empty   = 4'd0,
        tile_spike   = 4'd1,
        tile_gate_1  = 4'd2,
        tile_gate_2  = 4'd3,
        tile_gate_3  = 4'd4,
        tile_plate_1 = 4'd5,
        tile_plate_2 = 4'd6,
        tile_plate_3 = 4'd7,
        tile_exit    = 4'd8,
        tile_wall    = 4'd9
    } tile_t;

    typedef logic [9:0] coord_t;
    typedef logic [2:0] frame_t;

    typedef enum logic {
        anim_idle = 1'b0,
        anim_walk = 1'b1
    } anim_mode_t;

    typedef struct packed {
        logic left;
        logic right;
        logic jump;
    } player_ctrl_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   face_left;
        logic   jumping;
        logic   on_ground;
    } player_state_t;

    typedef struct packed {
        logic       wall_l;
        logic       wall_r;
        logic       ceiling;
        logic       floor;
        logic [3:0] floor_row;
    } contact_t;

    // geometry in pixels
    localparam int     MAP_COLS    = 20;
    localparam int     MAP_ROWS    = 15;
    localparam coord_t TILE_SIZE   = 10'd32;
    localparam coord_t STEP_PX     = 10'd5;
    localparam coord_t JUMP_HEIGHT = 10'd64;
    localparam coord_t FLOOR_Y     = 10'd416;
    localparam coord_t CEILING_Y   = 10'd10;
    localparam coord_t SCREEN_W    = 10'd640;
    localparam coord_t FOOT_INSET  = 10'd4;
    localparam coord_t PROBE_GAP   = 10'd5;

    localparam coord_t P0_START_X = 10'd32;
    localparam coord_t P0_START_Y = 10'd320;
    localparam coord_t P1_START_X = 10'd32;
    localparam coord_t P1_START_Y = 10'd416;

    // timing in clk_25MHz cycles
    localparam int FRAME_TICKS = 4000000;
    localparam int SPIKE_TICKS = 25000000;
    localparam int WALK_FRAMES = 6;
    localparam int IDLE_FRAMES = 4;

    // one nibble per tile, column 0 in the top nibble
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_09 = {{7{tile_empty}}, tile_gate_1,
        {4{tile_empty}}, tile_gate_2, {4{tile_empty}}, tile_gate_3, tile_empty, tile_exit};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_10 = {{5{tile_empty}}, tile_spike, tile_empty,
        tile_gate_1, {4{tile_empty}}, tile_gate_2, {4{tile_empty}}, tile_gate_3, tile_empty,
        tile_exit};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_11 = {{2{tile_wall}}, {3{tile_plate_1}},
        {15{tile_wall}}};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_13 = {{2{tile_empty}}, tile_spike, tile_empty,
        tile_gate_1, {10{tile_empty}}, {5{tile_plate_3}}};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_14 = {{5{tile_wall}}, {5{tile_plate_1}},
        {5{tile_plate_2}}, {5{tile_wall}}};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_OPEN = {20{tile_empty}};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_LEDGE_R = {{10{tile_empty}}, {10{tile_wall}}};
    localparam logic [MAP_COLS*4-1:0] MAP_ROW_LEDGE_L = {{10{tile_wall}}, {10{tile_empty}}};

    // row 0 first
    localparam logic [0:MAP_ROWS-1][MAP_COLS*4-1:0] MAP_ROWS_INIT = {
        MAP_ROW_OPEN, MAP_ROW_LEDGE_R, MAP_ROW_OPEN, MAP_ROW_LEDGE_L, MAP_ROW_OPEN,
        MAP_ROW_LEDGE_L, MAP_ROW_OPEN, MAP_ROW_LEDGE_L, MAP_ROW_OPEN, MAP_ROW_09,
        MAP_ROW_10, MAP_ROW_11, MAP_ROW_OPEN, MAP_ROW_13, MAP_ROW_14
    };

endpackage

`default_nettype wire

// ==== logic/world_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module world_map (
    input  platform_pkg::player_state_t state_p0,
    input  platform_pkg::player_state_t state_p1,
    output platform_pkg::contact_t      contact_p0,
    output platform_pkg::contact_t      contact_p1,
    output logic [2:0]                  gate_open
);
    import platform_pkg::*;

    player_state_t st [2];
    contact_t      ct [2];
    // raw floor tiles under each foot, before gate state is applied
    tile_t         foot_tile_l [2];
    tile_t         foot_tile_r [2];

    function automatic tile_t map_tile(input logic [4:0] row, input logic [4:0] col);
        if (row >= MAP_ROWS || col >= MAP_COLS) begin
            return tile_empty;
        end
        return tile_t'(MAP_ROWS_INIT[row[3:0]][(MAP_COLS - 1 - col) * 4 +: 4]);
    endfunction

    // plates and walls always block, a gate only while its plate is free
    function automatic logic blocks(input tile_t t, input logic [2:0] open);
        if (t >= tile_plate_1) begin
            return 1'b1;
        end
        if (t >= tile_gate_1 && t <= tile_gate_3) begin
            return !open[2'(t - tile_gate_1)];
        end
        return 1'b0;
    endfunction

    assign st[0]      = state_p0;
    assign st[1]      = state_p1;
    assign contact_p0 = ct[0];
    assign contact_p1 = ct[1];

    for (genvar p = 0; p < 2; p++) begin : g_probe
        coord_t foot_l;
        coord_t foot_r;
        coord_t below_y;
        coord_t above_y;
        coord_t side_l;
        coord_t side_r;
        coord_t top_y;
        coord_t mid_y;
        tile_t  side_l_top;
        tile_t  side_l_mid;
        tile_t  side_r_top;
        tile_t  side_r_mid;
        tile_t  ceil_l;
        tile_t  ceil_r;

        // probe points around the 32x32 box
        assign foot_l  = st[p].x + FOOT_INSET;
        assign foot_r  = st[p].x + TILE_SIZE - FOOT_INSET - 10'd1;
        assign below_y = st[p].y + TILE_SIZE;
        assign above_y = st[p].y - 10'd1;
        assign side_l  = st[p].x - PROBE_GAP;
        assign side_r  = st[p].x + TILE_SIZE - 10'd1 + PROBE_GAP;
        assign top_y   = st[p].y + FOOT_INSET;
        assign mid_y   = st[p].y + (TILE_SIZE >> 1);

        // below the last row is solid ground
        assign foot_tile_l[p] = (below_y[9:5] < MAP_ROWS) ?
                                map_tile(below_y[9:5], foot_l[9:5]) : tile_wall;
        assign foot_tile_r[p] = (below_y[9:5] < MAP_ROWS) ?
                                map_tile(below_y[9:5], foot_r[9:5]) : tile_wall;

        // too close to the left edge to probe, treat as wall
        assign side_l_top = (st[p].x < PROBE_GAP) ? tile_wall :
                            map_tile(top_y[9:5], side_l[9:5]);
        assign side_l_mid = (st[p].x < PROBE_GAP) ? tile_wall :
                            map_tile(mid_y[9:5], side_l[9:5]);
        // past the right edge map_tile already gives empty
        assign side_r_top = map_tile(top_y[9:5], side_r[9:5]);
        assign side_r_mid = map_tile(mid_y[9:5], side_r[9:5]);

        assign ceil_l = (st[p].y == '0) ? tile_empty : map_tile(above_y[9:5], foot_l[9:5]);
        assign ceil_r = (st[p].y == '0) ? tile_empty : map_tile(above_y[9:5], foot_r[9:5]);

        assign ct[p] = '{
            wall_l:    blocks(side_l_top, gate_open) | blocks(side_l_mid, gate_open),
            wall_r:    blocks(side_r_top, gate_open) | blocks(side_r_mid, gate_open),
            ceiling:   blocks(ceil_l, gate_open) | blocks(ceil_r, gate_open),
            floor:     blocks(foot_tile_l[p], gate_open) | blocks(foot_tile_r[p], gate_open),
            floor_row: below_y[8:5]
        };
    end

    // gate n opens while either left foot rests on plate n
    always_comb begin
        for (int g = 0; g < 3; g++) begin
            gate_open[g] = (foot_tile_l[0] == tile_t'(int'(tile_plate_1) + g)) ||
                           (foot_tile_l[1] == tile_t'(int'(tile_plate_1) + g));
        end
    end

endmodule

`default_nettype wire

// ==== logic/player_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_motion #(
    parameter platform_pkg::coord_t START_X = platform_pkg::P0_START_X,
    parameter platform_pkg::coord_t START_Y = platform_pkg::P0_START_Y
) (
    input  logic                        clk_25MHz,
    input  logic                        rst,
    input  logic                        step,
    input  platform_pkg::player_ctrl_t  ctrl,
    input  platform_pkg::contact_t      contact,
    output platform_pkg::player_state_t state
);
    import platform_pkg::*;

    // last x that can still take a full step right
    localparam coord_t RIGHT_LIMIT = SCREEN_W - TILE_SIZE - STEP_PX;

    coord_t jump_start;
    coord_t land_y;
    logic   jump_go;
    logic   jump_done;

    // top of the tile row the feet are standing on
    assign land_y = coord_t'({1'b0, contact.floor_row, 5'd0}) - TILE_SIZE;

    assign jump_go = ctrl.jump && state.on_ground && !state.jumping;

    // ceiling, full height reached, or top of the screen
    assign jump_done = contact.ceiling ||
                       (state.y + JUMP_HEIGHT <= jump_start) ||
                       (state.y <= CEILING_Y);

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            state.x         <= START_X;
            state.y         <= START_Y;
            state.face_left <= 1'b0;
            state.jumping   <= 1'b0;
            state.on_ground <= 1'b1;
        end else if (step) begin
            // left wins when both are held and it can move
            if (ctrl.left && state.x >= STEP_PX && !contact.wall_l) begin
                state.x         <= state.x - STEP_PX;
                state.face_left <= 1'b1;
            end else if (ctrl.right && state.x < RIGHT_LIMIT && !contact.wall_r) begin
                state.x         <= state.x + STEP_PX;
                state.face_left <= 1'b0;
            end

            if (state.jumping) begin
                if (jump_done) begin
                    state.jumping <= 1'b0;
                end else begin
                    state.y <= state.y - STEP_PX;
                end
            end else if (contact.floor || state.y >= FLOOR_Y) begin
                state.on_ground <= 1'b1;
                state.y         <= (state.y >= FLOOR_Y) ? FLOOR_Y : land_y;
            end else begin
                state.on_ground <= 1'b0;
                state.y         <= state.y + STEP_PX;
            end

            // takes over on_ground from the landing branch above
            if (jump_go) begin
                state.jumping   <= 1'b1;
                state.on_ground <= 1'b0;
            end
        end
    end

    // height at take-off
    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            jump_start <= START_Y;
        end else if (step && jump_go) begin
            jump_start <= state.y;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sprite_animator.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_animator #(
    parameter int FRAME_PERIOD = platform_pkg::FRAME_TICKS
) (
    input  logic                 clk_25MHz,
    input  logic                 rst,
    input  logic                 moving,
    output platform_pkg::frame_t frame
);
    import platform_pkg::*;

    localparam int CNT_W = $clog2(FRAME_PERIOD + 1);

    anim_mode_t       mode;
    logic [CNT_W-1:0] tick_cnt;
    frame_t           last_frame;

    assign last_frame = (mode == anim_walk) ? frame_t'(WALK_FRAMES - 1) :
                                              frame_t'(IDLE_FRAMES - 1);

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            mode     <= anim_idle;
            tick_cnt <= '0;
            frame    <= '0;
        end else if ((mode == anim_walk) != moving) begin
            // new sequence starts from frame 0
            mode     <= moving ? anim_walk : anim_idle;
            tick_cnt <= '0;
            frame    <= '0;
        end else if (tick_cnt == CNT_W'(FRAME_PERIOD)) begin
            tick_cnt <= '0;
            frame    <= (frame == last_frame) ? frame_t'(0) : frame + 3'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/spike_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spike_timer #(
    parameter int PHASE_PERIOD = platform_pkg::SPIKE_TICKS
) (
    input  logic clk_25MHz,
    input  logic rst,
    output logic spike_on
);

    localparam int CNT_W = $clog2(PHASE_PERIOD + 1);

    logic [CNT_W-1:0] tick_cnt;
    logic [1:0]       phase;

    // spikes are out for the second half of the four phases
    assign spike_on = phase[1];

    always_ff @(posedge clk_25MHz or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            phase    <= 2'd0;
        end else if (tick_cnt == CNT_W'(PHASE_PERIOD)) begin
            tick_cnt <= '0;
            phase    <= phase + 2'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/platform_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module platform_core #(
    parameter int FRAME_PERIOD = platform_pkg::FRAME_TICKS,
    parameter int PHASE_PERIOD = platform_pkg::SPIKE_TICKS
) (
    input  logic                        clk_25MHz,
    input  logic                        rst,
    input  logic                        step,
    input  platform_pkg::player_ctrl_t  ctrl_p0,
    input  platform_pkg::player_ctrl_t  ctrl_p1,
    output platform_pkg::player_state_t state_p0,
    output platform_pkg::player_state_t state_p1,
    output platform_pkg::frame_t        frame_p0,
    output platform_pkg::frame_t        frame_p1,
    output logic [2:0]                  gate_open,
    output logic                        spike_on
);
    import platform_pkg::*;

    contact_t contact_p0;
    contact_t contact_p1;

    // collision and gates follow the registered positions
    world_map map0 (
        .state_p0   (state_p0),
        .state_p1   (state_p1),
        .contact_p0 (contact_p0),
        .contact_p1 (contact_p1),
        .gate_open  (gate_open)
    );

    player_motion #(
        .START_X (P0_START_X),
        .START_Y (P0_START_Y)
    ) player_p0 (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .step      (step),
        .ctrl      (ctrl_p0),
        .contact   (contact_p0),
        .state     (state_p0)
    );

    player_motion #(
        .START_X (P1_START_X),
        .START_Y (P1_START_Y)
    ) player_p1 (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .step      (step),
        .ctrl      (ctrl_p1),
        .contact   (contact_p1),
        .state     (state_p1)
    );

    sprite_animator #(
        .FRAME_PERIOD (FRAME_PERIOD)
    ) anim_p0 (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .moving    (ctrl_p0.left | ctrl_p0.right),
        .frame     (frame_p0)
    );

    sprite_animator #(
        .FRAME_PERIOD (FRAME_PERIOD)
    ) anim_p1 (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .moving    (ctrl_p1.left | ctrl_p1.right),
        .frame     (frame_p1)
    );

    spike_timer #(
        .PHASE_PERIOD (PHASE_PERIOD)
    ) spikes0 (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .spike_on  (spike_on)
    );

endmodule

`default_nettype wire

// ==== bench/platform_model.svh ====
`ifndef PLATFORM_MODEL_SVH
`define PLATFORM_MODEL_SVH

// model state for both players, the animators and the spikes
player_state_t ref_st [2];
int            ref_jump_start [2];
int            ref_anim_cnt [2];
int            ref_frame [2];
logic          ref_walking [2];
int            ref_spike_cnt;
int            ref_phase;

// off the map reads as empty
function automatic int tile_at(input int row, input int col);
    if (row < 0 || row >= MAP_ROWS || col < 0 || col >= MAP_COLS) begin
        return 0;
    end
    return int'(MAP_ROWS_INIT[row][(MAP_COLS - 1 - col) * 4 +: 4]);
endfunction

// tile under a foot, solid below the bottom row
function automatic int ground_tile(input int fx, input int y);
    if ((y + 32) / 32 >= MAP_ROWS) begin
        return 9;
    end
    return tile_at((y + 32) / 32, fx / 32);
endfunction

function automatic logic solid(input int t, input logic [2:0] open);
    if (t >= 2 && t <= 4) begin
        return !open[t - 2];
    end
    return t >= 5;
endfunction

// plate n under either left foot opens gate n
function automatic logic [2:0] ref_gates();
    logic [2:0] open;
    int         lf0;
    int         lf1;
    lf0 = ground_tile(int'(ref_st[0].x) + 4, int'(ref_st[0].y));
    lf1 = ground_tile(int'(ref_st[1].x) + 4, int'(ref_st[1].y));
    for (int g = 0; g < 3; g++) begin
        open[g] = (lf0 == 5 + g) || (lf1 == 5 + g);
    end
    return open;
endfunction

function automatic contact_t ref_contact(input player_state_t s, input logic [2:0] open);
    contact_t c;
    int       x;
    int       y;
    x = int'(s.x);
    y = int'(s.y);
    c.wall_l = (x < 5) || solid(tile_at((y + 4) / 32, (x - 5) / 32), open) ||
               solid(tile_at((y + 16) / 32, (x - 5) / 32), open);
    c.wall_r = solid(tile_at((y + 4) / 32, (x + 36) / 32), open) ||
               solid(tile_at((y + 16) / 32, (x + 36) / 32), open);
    c.ceiling = (y != 0) && (solid(tile_at((y - 1) / 32, (x + 4) / 32), open) ||
                solid(tile_at((y - 1) / 32, (x + 27) / 32), open));
    c.floor = solid(ground_tile(x + 4, y), open) || solid(ground_tile(x + 27, y), open);
    c.floor_row = 4'((y + 32) / 32);
    return c;
endfunction

function automatic void move_player(input int p, input player_ctrl_t k, input contact_t c);
    player_state_t n;
    int            x;
    int            y;
    n = ref_st[p];
    x = int'(n.x);
    y = int'(n.y);
    if (k.left && x >= 5 && !c.wall_l) begin
        n.x = coord_t'(x - 5);
        n.face_left = 1'b1;
    end else if (k.right && x < 603 && !c.wall_r) begin
        n.x = coord_t'(x + 5);
        n.face_left = 1'b0;
    end
    if (ref_st[p].jumping) begin
        if (c.ceiling || y <= ref_jump_start[p] - 64 || y <= 10) begin
            n.jumping = 1'b0;
        end else begin
            n.y = coord_t'(y - 5);
        end
    end else if (c.floor || y >= 416) begin
        n.on_ground = 1'b1;
        n.y = coord_t'((y >= 416) ? 416 : int'(c.floor_row) * 32 - 32);
    end else begin
        n.on_ground = 1'b0;
        n.y = coord_t'(y + 5);
    end
    // take-off clears on_ground even on a landing step
    if (k.jump && ref_st[p].on_ground && !ref_st[p].jumping) begin
        n.jumping = 1'b1;
        n.on_ground = 1'b0;
        ref_jump_start[p] = y;
    end
    ref_st[p] = n;
endfunction

function automatic void tick_anim(input int p, input logic moving);
    if (moving != ref_walking[p]) begin
        ref_walking[p] = moving;
        ref_anim_cnt[p] = 0;
        ref_frame[p] = 0;
    end else if (ref_anim_cnt[p] == TB_FRAME_PERIOD) begin
        ref_anim_cnt[p] = 0;
        // six walk frames, four idle frames
        ref_frame[p] = (ref_frame[p] == (ref_walking[p] ? 5 : 3)) ? 0 : ref_frame[p] + 1;
    end else begin
        ref_anim_cnt[p]++;
    end
endfunction

function automatic void model_reset();
    ref_st[0] = '{x: P0_START_X, y: P0_START_Y, face_left: 1'b0, jumping: 1'b0,
                  on_ground: 1'b1};
    ref_st[1] = '{x: P1_START_X, y: P1_START_Y, face_left: 1'b0, jumping: 1'b0,
                  on_ground: 1'b1};
    for (int p = 0; p < 2; p++) begin
        ref_jump_start[p] = 0;
        ref_anim_cnt[p] = 0;
        ref_frame[p] = 0;
        ref_walking[p] = 1'b0;
    end
    ref_spike_cnt = 0;
    ref_phase = 0;
endfunction

// one rising clock edge with the given inputs
function automatic void model_clock(input logic stp, input player_ctrl_t k0,
                                    input player_ctrl_t k1);
    logic [2:0] open;
    contact_t   c0;
    contact_t   c1;
    open = ref_gates();
    c0 = ref_contact(ref_st[0], open);
    c1 = ref_contact(ref_st[1], open);
    if (stp) begin
        move_player(0, k0, c0);
        move_player(1, k1, c1);
    end
    tick_anim(0, k0.left | k0.right);
    tick_anim(1, k1.left | k1.right);
    if (ref_spike_cnt == TB_PHASE_PERIOD) begin
        ref_spike_cnt = 0;
        ref_phase = (ref_phase + 1) % 4;
    end else begin
        ref_spike_cnt++;
    end
endfunction

`endif

// ==== bench/platform_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module platform_tb;
    import platform_pkg::*;

    localparam int TB_FRAME_PERIOD = 7;
    localparam int TB_PHASE_PERIOD = 11;
    // tests and resets take about 2,700 cycles
    localparam int CYCLE_LIMIT = 20000;
    localparam player_ctrl_t IDLE     = 3'b000;
    localparam player_ctrl_t GO_RIGHT = 3'b010;
    localparam player_ctrl_t GO_LEFT  = 3'b100;

    logic          clk_25MHz;
    logic          rst;
    logic          step;
    player_ctrl_t  ctrl_p0;
    player_ctrl_t  ctrl_p1;
    player_state_t state_p0;
    player_state_t state_p1;
    frame_t        frame_p0;
    frame_t        frame_p1;
    logic [2:0]    gate_open;
    logic          spike_on;
    integer        seed;
    int            cycle_count;
    int            test_errors;
    int            total_errors;
    int            bad_tests;
    int            tests_run;

    `include "platform_model.svh"

    platform_core #(
        .FRAME_PERIOD (TB_FRAME_PERIOD),
        .PHASE_PERIOD (TB_PHASE_PERIOD)
    ) dut0 (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .step      (step),
        .ctrl_p0   (ctrl_p0),
        .ctrl_p1   (ctrl_p1),
        .state_p0  (state_p0),
        .state_p1  (state_p1),
        .frame_p0  (frame_p0),
        .frame_p1  (frame_p1),
        .gate_open (gate_open),
        .spike_on  (spike_on)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever begin
            #20 clk_25MHz = ~clk_25MHz;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (got !== exp) begin
            $display("FAIL %s expected %h got %h at %0t", name, exp, got, $time);
            test_errors++;
        end
    endtask

    task automatic compare_all();
        check_value("state_p0", 32'(ref_st[0]), 32'(state_p0));
        check_value("state_p1", 32'(ref_st[1]), 32'(state_p1));
        check_value("frame_p0", 32'(ref_frame[0]), 32'(frame_p0));
        check_value("frame_p1", 32'(ref_frame[1]), 32'(frame_p1));
        check_value("gate_open", 32'(ref_gates()), 32'(gate_open));
        check_value("spike_on", 32'(ref_phase >= 2), 32'(spike_on));
    endtask

    // drive on the falling edge, check just after the rising edge
    task automatic run_cycle(input logic stp, input player_ctrl_t k0, input player_ctrl_t k1);
        @(negedge clk_25MHz);
        step = stp;
        ctrl_p0 = k0;
        ctrl_p1 = k1;
        model_clock(stp, k0, k1);
        @(posedge clk_25MHz);
        #1;
        compare_all();
    endtask

    task automatic do_step(input player_ctrl_t k0, input player_ctrl_t k1);
        run_cycle(1'b1, k0, k1);
        run_cycle(1'b0, k0, k1);
    endtask

    task automatic apply_reset();
        @(negedge clk_25MHz);
        rst = 1'b1;
        step = 1'b0;
        ctrl_p0 = IDLE;
        ctrl_p1 = IDLE;
        repeat (10) @(negedge clk_25MHz);
        rst = 1'b0;
        model_reset();
        compare_all();
        model_clock(1'b0, IDLE, IDLE);
        @(posedge clk_25MHz);
        #1;
        compare_all();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            bad_tests++;
        end
        $display("test %0d, %s: %0d mismatches", tests_run, name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        player_ctrl_t c0;
        player_ctrl_t c1;
        logic [31:0]  r;
        int           hold [2];
        int           x_exp;
        seed = 95155;
        rst = 1'b1;
        step = 1'b0;
        ctrl_p0 = IDLE;
        ctrl_p1 = IDLE;
        test_errors = 0;
        total_errors = 0;
        bad_tests = 0;
        tests_run = 0;

        apply_reset();
        check_value("state_p0", {9'd0, 10'd32, 10'd320, 3'b001}, 32'(state_p0));
        check_value("state_p1", {9'd0, 10'd32, 10'd416, 3'b001}, 32'(state_p1));
        check_value("frame_p0", 32'd0, 32'(frame_p0));
        check_value("frame_p1", 32'd0, 32'(frame_p1));
        check_value("spike_on", 32'd0, 32'(spike_on));
        end_test("reset values");

        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            do_step({r[0], r[1], 1'b0}, {r[2], r[3], 1'b0});
        end
        end_test("walking and wall blocking");

        for (int i = 0; i < 600; i++) begin
            r = $random(seed);
            do_step({r[0], r[1], r[4] & r[5]}, {r[2], r[3], r[6] & r[7]});
        end
        end_test("jump and gravity");

        // p0 holds gate 1 open while p1 gets past it
        apply_reset();
        repeat (6) do_step(GO_RIGHT, IDLE);
        check_value("gate_open[0]", 32'd1, 32'(gate_open[0]));
        repeat (19) do_step(IDLE, GO_RIGHT);
        do_step(GO_LEFT, IDLE);
        check_value("gate_open[0]", 32'd0, 32'(gate_open[0]));
        for (int k = 1; k <= 38; k++) begin
            do_step(IDLE, GO_RIGHT);
            x_exp = 127 + 5 * k;
            check_value("state_p1.x", 32'(x_exp), 32'(state_p1.x));
            // plate 1 covers floor columns 5 to 9
            check_value("gate_open[0]", 32'(x_exp + 4 >= 160 && x_exp + 4 < 320),
                        32'(gate_open[0]));
        end
        end_test("plate opens gate");

        c0 = IDLE;
        c1 = IDLE;
        hold[0] = 1;
        hold[1] = 1;
        for (int i = 0; i < 320; i++) begin
            for (int p = 0; p < 2; p++) begin
                hold[p]--;
                if (hold[p] == 0) begin
                    r = $random(seed);
                    hold[p] = 1 + int'(r[5:0]);
                    if (p == 0) begin
                        c0.right = !c0.right;
                    end else begin
                        c1.left = !c1.left;
                    end
                end
            end
            run_cycle(1'b0, c0, c1);
        end
        end_test("animation frames");

        apply_reset();
        repeat (200) run_cycle(1'b0, IDLE, IDLE);
        end_test("spike timer");

        $display("summary: %0d tests, %0d with mismatches, %0d mismatches in all",
                 tests_run, bad_tests, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_25MHz);
            cycle_count++;
        end
        $display("timeout: no result after %0d clock cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== platform_game.f ====
+incdir+bench
logic/platform_pkg.sv
logic/world_map.sv
logic/player_motion.sv
logic/sprite_animator.sv
logic/spike_timer.sv
logic/platform_core.sv
bench/platform_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the platform testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f platform_game.f --top-module platform_tb
./obj_dir/Vplatform_tb > sim.log 2>&1
cat sim.log
if grep -qx "all tests passed" sim.log; then
    exit 0
fi
exit 1
